/* hw/pulse_shape_pkg.sv */
package pulse_shape_pkg;

	// Sample formats
	typedef logic signed [17:0] sample_t;
	typedef logic signed [18:0] pair_sum_t;
	typedef logic signed [36:0] product_t;
	typedef logic signed [17:0] coeff_t;

	// Filter geometry
	localparam int NUM_TAPS = 105;
	localparam int NUM_PAIRS = (NUM_TAPS - 1) / 2;
	localparam int NUM_PRODUCTS = NUM_PAIRS + 1;

	// Symbol levels on the 1s17 scale
	localparam int LEVEL_STEP = 32768;
	localparam int LEVEL_SHIFT = $clog2(LEVEL_STEP);
	localparam int MAX_LEVELS = 6;

	// Bits dropped from each full product before the adder chain
	localparam int PRODUCT_SHIFT = 18;

	// Signed count of level steps held in a pair sum
	typedef logic signed [$bits(pair_sum_t)-LEVEL_SHIFT-1:0] level_t;

	// Index 0 is the outermost pair, the last entry is the centre tap
	localparam coeff_t COEFFS [NUM_PRODUCTS] = '{
		-619,
		-401,
		147,
		672,
		790,
		354,
		-404,
		-992,
		-969,
		-259,
		740,
		1375,
		1153,
		104,
		-1170,
		-1828,
		-1337,
		130,
		1716,
		2366,
		1518,
		-465,
		-2409,
		-3011,
		-1690,
		936,
		3300,
		3800,
		1850,
		-1598,
		-4475,
		-4801,
		-1993,
		2553,
		6099,
		6150,
		2116,
		-4008,
		-8528,
		-8159,
		-2216,
		6470,
		12693,
		11699,
		2289,
		-11610,
		-22018,
		-20455,
		-2333,
		30008,
		67374,
		97118,
		// Centre
		108441
	};

endpackage

/* hw/filter_control.sv */
`timescale 1ns/1ns

module filter_control (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  logic out_ready,
	output logic in_ready,
	output logic out_valid,
	output logic shift,
	output logic prod_load,
	output logic sum_load
);

	logic advance;
	// Fresh sample in the delay line but not yet in the product registers
	logic tap_valid;
	logic prod_valid;

	// Whole pipeline moves together unless a result is waiting on the sink
	assign advance = !out_valid || out_ready;

	assign in_ready = advance;
	assign shift = in_valid && in_ready;
	assign prod_load = advance;
	assign sum_load = advance;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			tap_valid <= 1'b0;
			prod_valid <= 1'b0;
			out_valid <= 1'b0;
		end
		else if (advance)
		begin
			tap_valid <= shift;
			prod_valid <= tap_valid;
			out_valid <= prod_valid;
		end
	end

	// A stalled result stays offered until the sink takes it
	stall_holds_valid: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid);

	// A refused sample stays offered by the source
	source_holds_valid: assert property (@(posedge clk) disable iff (reset)
		in_valid && !in_ready |=> in_valid);

endmodule

/* hw/tap_delay_line.sv */
`timescale 1ns/1ns

module tap_delay_line
	import pulse_shape_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      shift,
	input  sample_t   in_sample,
	output pair_sum_t pair_sums [NUM_PRODUCTS]
);

	// Tap 0 holds the newest sample
	sample_t taps [NUM_TAPS];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_TAPS; i++)
				taps[i] <= '0;
		end
		else if (shift)
		begin
			taps[0] <= in_sample;
			for (int i = 1; i < NUM_TAPS; i++)
				taps[i] <= taps[i-1];
		end
	end

	// Mirrored taps share a coefficient, so add them before the multiply
	always_comb
	begin
		for (int i = 0; i < NUM_PAIRS; i++)
			pair_sums[i] = pair_sum_t'(taps[i]) + pair_sum_t'(taps[NUM_TAPS-1-i]);

		// Centre tap has no partner
		pair_sums[NUM_PAIRS] = pair_sum_t'(taps[NUM_PAIRS]);
	end

endmodule

/* hw/level_product_bank.sv */
`timescale 1ns/1ns

module level_product_bank
	import pulse_shape_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      load,
	input  pair_sum_t pair_sums [NUM_PRODUCTS],
	output sample_t   products [NUM_PRODUCTS]
);

	level_t                  levels [NUM_PRODUCTS];
	logic [NUM_PRODUCTS-1:0] on_grid;
	product_t                full_products [NUM_PRODUCTS];
	sample_t                 trunc_products [NUM_PRODUCTS];

	// A pair sum is a whole number of level steps; anything else maps to zero
	always_comb
	begin
		for (int i = 0; i < NUM_PRODUCTS; i++)
		begin
			levels[i] = level_t'(pair_sums[i] >>> LEVEL_SHIFT);
			on_grid[i] = (pair_sums[i][LEVEL_SHIFT-1:0] == '0) &&
				(levels[i] <= MAX_LEVELS) && (levels[i] >= -MAX_LEVELS);
		end
	end

	// Coefficient times level count, scaled back up by one level step
	always_comb
	begin
		for (int i = 0; i < NUM_PRODUCTS; i++)
		begin
			if (on_grid[i])
				full_products[i] = (product_t'(COEFFS[i]) * product_t'(levels[i]))
					<<< LEVEL_SHIFT;
			else
				full_products[i] = '0;
		end
	end

	// Keep the upper bits below the guard bit
	always_comb
	begin
		for (int i = 0; i < NUM_PRODUCTS; i++)
			trunc_products[i] = sample_t'(full_products[i] >>> PRODUCT_SHIFT);
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_PRODUCTS; i++)
				products[i] <= '0;
		end
		else if (load)
		begin
			for (int i = 0; i < NUM_PRODUCTS; i++)
				products[i] <= trunc_products[i];
		end
	end

endmodule

/* hw/tap_accumulator.sv */
`timescale 1ns/1ns

module tap_accumulator
	import pulse_shape_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    load,
	input  sample_t products [NUM_PRODUCTS],
	output sample_t out_sample
);

	// Running sums along the chain, wrapping at 18 bits
	sample_t chain [NUM_PRODUCTS];

	always_comb
	begin
		chain[0] = products[0];
		for (int i = 1; i < NUM_PRODUCTS; i++)
			chain[i] = chain[i-1] + products[i];
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			out_sample <= '0;
		else if (load)
			out_sample <= chain[NUM_PRODUCTS-1];
	end

endmodule

/* hw/pulse_shape_filter.sv */
`timescale 1ns/1ns

module pulse_shape_filter
	import pulse_shape_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    in_valid,
	input  sample_t in_sample,
	input  logic    out_ready,
	output logic    in_ready,
	output logic    out_valid,
	output sample_t out_sample
);

	logic      shift;
	logic      prod_load;
	logic      sum_load;
	pair_sum_t pair_sums [NUM_PRODUCTS];
	sample_t   products [NUM_PRODUCTS];

	filter_control i_filter_control (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.out_ready (out_ready),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.shift     (shift),
		.prod_load (prod_load),
		.sum_load  (sum_load)
	);

	tap_delay_line i_tap_delay_line (
		.clk       (clk),
		.reset     (reset),
		.shift     (shift),
		.in_sample (in_sample),
		.pair_sums (pair_sums)
	);

	level_product_bank i_level_product_bank (
		.clk       (clk),
		.reset     (reset),
		.load      (prod_load),
		.pair_sums (pair_sums),
		.products  (products)
	);

	tap_accumulator i_tap_accumulator (
		.clk        (clk),
		.reset      (reset),
		.load       (sum_load),
		.products   (products),
		.out_sample (out_sample)
	);

	// Output data must not move under a stall
	stall_holds_sample: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> $stable(out_sample));

endmodule

/* bench/tb_pulse_shape_filter.sv */
`timescale 1ns/1ns

module tb_pulse_shape_filter
	import pulse_shape_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 5;
	localparam int SEED = 32'h2b2a_98a7;
	localparam int IMPULSE_ZEROS = 110;
	localparam int STREAM_SAMPLES = 400;
	localparam int STALL_SAMPLES = 300;
	localparam int RESET_SPLIT = 60;
	localparam int RESET_TAIL = 90;
	localparam int TOTAL_SAMPLES = IMPULSE_ZEROS + 2 + STREAM_SAMPLES + STALL_SAMPLES
		+ RESET_SPLIT + RESET_TAIL;
	localparam int TIMEOUT_CYCLES = TOTAL_SAMPLES * 4 + 200;

	logic    clk = 1'b0;
	logic    reset;
	logic    in_valid;
	sample_t in_sample;
	logic    out_ready;
	logic    in_ready;
	logic    out_valid;
	sample_t out_sample;

	int      seed;
	logic    ready_random;
	string   test_name;
	sample_t history [NUM_TAPS];
	sample_t expected_q [$];
	sample_t seen_q [$];
	sample_t next_expected;
	sample_t held_sample;
	logic    stall_pending;
	int      stall_count;

	pulse_shape_filter i_pulse_shape_filter (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_sample  (in_sample),
		.out_ready  (out_ready),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_sample (out_sample)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Expected output for one delay-line state with tap 0 newest
	function automatic sample_t ref_output(input sample_t taps [NUM_TAPS]);
		pair_sum_t psum;
		product_t  full;
		sample_t   acc;
		acc = '0;
		for (int i = 0; i < NUM_PRODUCTS; i++)
		begin
			if (i < NUM_PAIRS)
				psum = pair_sum_t'(taps[i]) + pair_sum_t'(taps[NUM_TAPS-1-i]);
			else
				psum = pair_sum_t'(taps[i]);
			full = '0;
			if ((psum % LEVEL_STEP == 0) && (psum <= MAX_LEVELS * LEVEL_STEP) &&
				(psum >= -MAX_LEVELS * LEVEL_STEP))
				full = product_t'(COEFFS[i]) * product_t'(psum);
			acc = acc + sample_t'(full >>> PRODUCT_SHIFT);
		end
		return acc;
	endfunction

	function automatic sample_t random_symbol();
		int pick;
		pick = {$random(seed)} % 4;
		case (pick)
			0: return sample_t'(LEVEL_STEP);
			1: return sample_t'(-LEVEL_STEP);
			2: return sample_t'(3 * LEVEL_STEP);
			default: return sample_t'(-3 * LEVEL_STEP);
		endcase
	endfunction

	task automatic fail_run();
		$display("tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_sample(input string name, input sample_t expected,
		input sample_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
			fail_run();
		end
	endtask

	// Two more edges show whether an extra result follows the last one
	task automatic verify_drained(input string name);
		in_valid = 1'b0;
		repeat (2)
		begin
			@(negedge clk);
			check_flag({name, " out_valid low after drain"}, 1'b0, out_valid);
		end
	endtask

	// Input side monitor that builds the expected results
	always @(posedge clk)
	begin
		if (reset)
		begin
			expected_q.delete();
			for (int i = 0; i < NUM_TAPS; i++)
				history[i] = '0;
		end
		else if (in_valid && in_ready)
		begin
			for (int i = NUM_TAPS - 1; i > 0; i--)
				history[i] = history[i-1];
			history[0] = in_sample;
			expected_q.push_back(ref_output(history));
		end
	end

	// Output side compare and stall checks
	always @(posedge clk)
	begin
		if (reset)
			stall_pending = 1'b0;
		else
		begin
			if (stall_pending)
			begin
				check_flag({test_name, " out_valid held in stall"}, 1'b1, out_valid);
				check_sample({test_name, " out_sample held in stall"}, held_sample, out_sample);
			end
			if (out_valid && !out_ready)
			begin
				check_flag({test_name, " in_ready low in stall"}, 1'b0, in_ready);
				stall_pending = 1'b1;
				held_sample = out_sample;
				stall_count++;
			end
			else
				stall_pending = 1'b0;
			if (out_valid && out_ready)
			begin
				if (expected_q.size() == 0)
				begin
					$display("%s: an output arrived with no input left to match it", test_name);
					fail_run();
				end
				next_expected = expected_q.pop_front();
				check_sample(test_name, next_expected, out_sample);
				seen_q.push_back(out_sample);
			end
		end
	end

	task automatic update_ready();
		if (ready_random)
			out_ready = ({$random(seed)} % 3) != 0;
	endtask

	// Called at a falling edge and returns at the falling edge after the transfer
	task automatic send_sample(input sample_t value);
		logic accepted;
		in_valid = 1'b1;
		in_sample = value;
		do
		begin
			@(posedge clk);
			accepted = in_ready;
			if (!accepted)
			begin
				@(negedge clk);
				update_ready();
			end
		end while (!accepted);
		@(negedge clk);
		update_ready();
	endtask

	task automatic idle_cycle();
		in_valid = 1'b0;
		@(negedge clk);
		update_ready();
	endtask

	task automatic wait_drain();
		in_valid = 1'b0;
		while (expected_q.size() != 0)
		begin
			@(negedge clk);
			update_ready();
		end
	endtask

	task automatic apply_reset();
		in_valid = 1'b0;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic impulse_test();
		sample_t first_tap;
		sample_t centre_tap;
		test_name = "impulse";
		seen_q.delete();
		send_sample(sample_t'(LEVEL_STEP));
		repeat (IMPULSE_ZEROS) send_sample('0);
		wait_drain();
		if (seen_q.size() != IMPULSE_ZEROS + 1)
		begin
			$display("impulse: %0d results came out for %0d samples", seen_q.size(),
				IMPULSE_ZEROS + 1);
			fail_run();
		end
		// Response is the coefficient table scaled by one level step
		first_tap = sample_t'((product_t'(COEFFS[0]) * LEVEL_STEP) >>> PRODUCT_SHIFT);
		centre_tap = sample_t'((product_t'(COEFFS[NUM_PAIRS]) * LEVEL_STEP) >>> PRODUCT_SHIFT);
		check_sample("impulse first tap", first_tap, seen_q[0]);
		check_sample("impulse centre tap", centre_tap, seen_q[NUM_PAIRS]);
		for (int j = 1; j <= NUM_PAIRS; j++)
			check_sample("impulse symmetry", seen_q[NUM_PAIRS-j], seen_q[NUM_PAIRS+j]);
	endtask

	task automatic latency_test();
		test_name = "latency";
		in_valid = 1'b1;
		in_sample = sample_t'(-3 * LEVEL_STEP);
		check_flag("latency in_ready before accept", 1'b1, in_ready);
		@(posedge clk);
		@(negedge clk);
		in_valid = 1'b0;
		for (int edges = 0; edges <= 2; edges++)
		begin
			check_flag($sformatf("latency out_valid %0d edges after accept", edges),
				edges == 2, out_valid);
			if (edges < 2)
				@(negedge clk);
		end
		wait_drain();
	endtask

	task automatic stream_test();
		test_name = "random stream";
		repeat (STREAM_SAMPLES) send_sample(random_symbol());
		wait_drain();
		verify_drained(test_name);
	endtask

	task automatic backpressure_test();
		test_name = "back-pressure";
		stall_count = 0;
		ready_random = 1'b1;
		repeat (STALL_SAMPLES)
		begin
			if ({$random(seed)} % 4 == 0)
				idle_cycle();
			send_sample(random_symbol());
		end
		wait_drain();
		ready_random = 1'b0;
		out_ready = 1'b1;
		verify_drained(test_name);
		if (stall_count == 0)
		begin
			$display("back-pressure: the output never stalled during the test");
			fail_run();
		end
	endtask

	task automatic midstream_reset_test();
		test_name = "reset mid-stream";
		repeat (RESET_SPLIT) send_sample(random_symbol());
		apply_reset();
		check_flag("reset mid-stream out_valid", 1'b0, out_valid);
		check_flag("reset mid-stream in_ready", 1'b1, in_ready);
		repeat (RESET_TAIL) send_sample(random_symbol());
		wait_drain();
		verify_drained(test_name);
	endtask

	initial
	begin
		seed = SEED;
		ready_random = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_sample = '0;
		out_ready = 1'b1;
		stall_pending = 1'b0;
		stall_count = 0;
		test_name = "reset";
		apply_reset();
		check_flag("after reset out_valid", 1'b0, out_valid);
		check_flag("after reset in_ready", 1'b1, in_ready);
		impulse_test();
		latency_test();
		stream_test();
		backpressure_test();
		midstream_reset_test();
		$display("all tests passed");
		$finish;
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles, the outputs stopped arriving", TIMEOUT_CYCLES);
		fail_run();
	end

endmodule

/* build.f */
hw/pulse_shape_pkg.sv
hw/filter_control.sv
hw/tap_delay_line.sv
hw/level_product_bank.sv
hw/tap_accumulator.sv
hw/pulse_shape_filter.sv
bench/tb_pulse_shape_filter.sv

/* Makefile */
# Verilator build and run for the pulse-shaping filter testbench

VERILATOR ?= verilator
TOP       ?= tb_pulse_shape_filter
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
